//--- cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    ////////////////////////////////////////
    // sizes
    ////////////////////////////////////////

    localparam int ID_WIDTH  = 2;   // slots per rob row
    localparam int ROB_ROWS  = 8;
    localparam int CDB_WIDTH = 2;
    localparam int PRF_IDX   = 6;
    localparam int ARF_IDX   = 5;

    localparam int ROB_IDX  = $clog2(ROB_ROWS);
    localparam int SLOT_IDX = $clog2(ID_WIDTH);
    localparam int ROB_ID_W = ROB_IDX + SLOT_IDX;   // row number then slot

    ////////////////////////////////////////
    // block to block payloads
    ////////////////////////////////////////

    typedef struct packed {
        logic                               valid;
        logic [ID_WIDTH-1:0]                slot_valid;
        logic [ID_WIDTH-1:0][PRF_IDX-1:0]   rd_phy;
        logic [ID_WIDTH-1:0][ARF_IDX-1:0]   rd_arch;
    } dispatch_t;

    typedef struct packed {
        logic                   valid;
        logic [ROB_ID_W-1:0]    rob_id;
    } cdb_t;

    typedef struct packed {
        logic                   valid;
        logic [PRF_IDX-1:0]     rd_phy;
        logic [ARF_IDX-1:0]     rd_arch;
    } commit_t;

    typedef struct packed {
        logic                   valid;
        logic [PRF_IDX-1:0]     phy;
    } freed_t;

    typedef struct packed {
        logic                   valid;
        logic [ROB_ID_W-1:0]    rob_id;
    } br_alloc_t;

    typedef struct packed {
        logic                   valid;
        logic [ROB_ID_W-1:0]    rob_id;
        logic                   miss_predict;
        logic [31:0]            target;
    } br_resolve_t;

    typedef struct packed {
        logic                   ready;      // not empty and resolved
        logic [ROB_ID_W-1:0]    rob_id;
        logic                   miss_predict;
        logic [31:0]            target;
    } cb_head_t;

endpackage

`default_nettype wire

//--- rob.sv
`timescale 1ns/1ps
`default_nettype none

module rob
import cpu_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst,

    input  dispatch_t               dispatch,
    output logic                    rob_ready,
    output logic [ROB_ID_W-1:0]     rob_ids [ID_WIDTH],

    input  cdb_t                    cdb [CDB_WIDTH],

    input  cb_head_t                cb_head,
    output logic                    cb_dequeue,
    output logic                    flush,
    output logic [31:0]             redirect_pc,

    output commit_t                 commit [ID_WIDTH]
);

    typedef struct packed {
        logic [PRF_IDX-1:0]     rd_phy;
        logic [ARF_IDX-1:0]     rd_arch;
    } dest_t;

    logic [ID_WIDTH-1:0]    slot_valid [ROB_ROWS];
    logic [ID_WIDTH-1:0]    slot_ready [ROB_ROWS];
    dest_t                  dest_arr   [ROB_ROWS][ID_WIDTH];

    logic [ROB_IDX:0]       head_ptr;   // msb is the wrap bit
    logic [ROB_IDX:0]       tail_ptr;
    logic [ROB_IDX-1:0]     head;
    logic [ROB_IDX-1:0]     tail;

    logic                   full;
    logic                   empty;
    logic                   push;
    logic                   pop;

    function automatic logic [ROB_IDX-1:0] row_of(input logic [ROB_ID_W-1:0] id);
        return id[ROB_ID_W-1 -: ROB_IDX];
    endfunction

    function automatic logic [SLOT_IDX-1:0] slot_of(input logic [ROB_ID_W-1:0] id);
        return id[SLOT_IDX-1:0];
    endfunction

    assign head = head_ptr[ROB_IDX-1:0];
    assign tail = tail_ptr[ROB_IDX-1:0];

    assign full  = (head == tail) && (head_ptr[ROB_IDX] != tail_ptr[ROB_IDX]);
    assign empty = (head == tail) && (head_ptr[ROB_IDX] == tail_ptr[ROB_IDX]);

    assign rob_ready = ~full;
    assign push      = dispatch.valid && rob_ready;

    // head row leaves once every valid slot has completed
    assign pop = ~empty && ((slot_valid[head] & ~slot_ready[head]) == '0);

    ////////////////////////////////////////
    // queue state
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_ptr <= '0;
            tail_ptr <= '0;
            for (int r = 0; r < ROB_ROWS; r++) begin
                slot_valid[r] <= '0;
                slot_ready[r] <= '0;
            end
        end else begin
            if (push) begin
                tail_ptr         <= tail_ptr + 1'b1;
                slot_valid[tail] <= dispatch.slot_valid;
                slot_ready[tail] <= '0;
            end

            if (pop) begin
                head_ptr <= head_ptr + 1'b1;
            end

            for (int k = 0; k < CDB_WIDTH; k++) begin   // snoop cdb
                if (cdb[k].valid) begin
                    slot_ready[row_of(cdb[k].rob_id)][slot_of(cdb[k].rob_id)] <= 1'b1;
                end
            end
        end
    end

    // destination fields
    always_ff @(posedge clk) begin
        if (push) begin
            for (int i = 0; i < ID_WIDTH; i++) begin
                dest_arr[tail][i].rd_phy  <= dispatch.rd_phy[i];
                dest_arr[tail][i].rd_arch <= dispatch.rd_arch[i];
            end
        end
    end

    ////////////////////////////////////////
    // dispatch ids and retirement
    ////////////////////////////////////////

    generate
        for (genvar i = 0; i < ID_WIDTH; i++) begin : g_slot
            assign rob_ids[i]        = {tail, SLOT_IDX'(i)};
            assign commit[i].valid   = pop && slot_valid[head][i];
            assign commit[i].rd_phy  = dest_arr[head][i].rd_phy;
            assign commit[i].rd_arch = dest_arr[head][i].rd_arch;
        end
    endgenerate

    // oldest branch must sit in the retiring row
    assign cb_dequeue  = pop && cb_head.ready && (row_of(cb_head.rob_id) == head);
    assign flush       = cb_dequeue && cb_head.miss_predict;
    assign redirect_pc = cb_head.target;

endmodule

`default_nettype wire

//--- control_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module control_buffer
import cpu_pkg::*;
#(
    parameter int CB_DEPTH = 4      // power of two
)
(
    input  logic            clk,
    input  logic            rst,

    input  br_alloc_t       br_alloc,
    output logic            cb_full,
    input  br_resolve_t     br_resolve,

    output cb_head_t        cb_head,
    input  logic            cb_dequeue,
    input  logic            flush
);

    localparam int CB_IDX = $clog2(CB_DEPTH);

    logic [CB_DEPTH-1:0]    ent_valid;
    logic [CB_DEPTH-1:0]    ent_resolved;
    logic [CB_DEPTH-1:0]    ent_miss;
    logic [ROB_ID_W-1:0]    ent_rob_id [CB_DEPTH];
    logic [31:0]            ent_target [CB_DEPTH];

    logic [CB_IDX:0]        head_ptr;
    logic [CB_IDX:0]        tail_ptr;
    logic [CB_IDX-1:0]      head;
    logic [CB_IDX-1:0]      tail;

    logic                   empty;
    logic                   alloc;
    logic                   alloc_hit;
    logic [CB_DEPTH-1:0]    resolve_hit;

    assign head = head_ptr[CB_IDX-1:0];
    assign tail = tail_ptr[CB_IDX-1:0];

    assign cb_full = (head == tail) && (head_ptr[CB_IDX] != tail_ptr[CB_IDX]);
    assign empty   = (head == tail) && (head_ptr[CB_IDX] == tail_ptr[CB_IDX]);

    assign alloc     = br_alloc.valid && ~cb_full;
    assign alloc_hit = br_resolve.valid && (br_resolve.rob_id == br_alloc.rob_id);

    always_comb begin
        for (int j = 0; j < CB_DEPTH; j++) begin
            resolve_hit[j] = br_resolve.valid && ent_valid[j]
                             && (ent_rob_id[j] == br_resolve.rob_id);
        end
    end

    ////////////////////////////////////////
    // entry state
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            head_ptr     <= '0;
            tail_ptr     <= '0;
            ent_valid    <= '0;
            ent_resolved <= '0;
        end else begin
            if (alloc) begin
                tail_ptr           <= tail_ptr + 1'b1;
                ent_valid[tail]    <= 1'b1;
                ent_resolved[tail] <= alloc_hit;    // resolved on arrival
            end

            for (int j = 0; j < CB_DEPTH; j++) begin
                if (resolve_hit[j]) begin
                    ent_resolved[j] <= 1'b1;
                end
            end

            if (cb_dequeue) begin
                head_ptr           <= head_ptr + 1'b1;
                ent_valid[head]    <= 1'b0;
                ent_resolved[head] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc) begin
            ent_rob_id[tail] <= br_alloc.rob_id;
            ent_miss[tail]   <= br_resolve.miss_predict;
            ent_target[tail] <= br_resolve.target;
        end
        for (int j = 0; j < CB_DEPTH; j++) begin
            if (resolve_hit[j]) begin
                ent_miss[j]   <= br_resolve.miss_predict;
                ent_target[j] <= br_resolve.target;
            end
        end
    end

    // oldest branch
    assign cb_head.ready        = ~empty && ent_resolved[head];
    assign cb_head.rob_id       = ent_rob_id[head];
    assign cb_head.miss_predict = ent_miss[head];
    assign cb_head.target       = ent_target[head];

endmodule

`default_nettype wire

//--- rrf.sv
`timescale 1ns/1ps
`default_nettype none

module rrf
import cpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,

    input  commit_t     commit [ID_WIDTH],
    output freed_t      freed  [ID_WIDTH]
);

    localparam int ARF_REGS = 2 ** ARF_IDX;

    // committed arch to phys map
    logic [PRF_IDX-1:0] map [ARF_REGS];

    ////////////////////////////////////////
    // freed register per slot
    ////////////////////////////////////////

    always_comb begin
        for (int i = 0; i < ID_WIDTH; i++) begin
            freed[i].valid = commit[i].valid;
            freed[i].phy   = map[commit[i].rd_arch];
            // an older slot of the same row wrote this register first
            for (int j = 0; j < i; j++) begin
                if (commit[j].valid && (commit[j].rd_arch == commit[i].rd_arch)) begin
                    freed[i].phy = commit[j].rd_phy;
                end
            end
        end
    end

    ////////////////////////////////////////
    // map update
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int a = 0; a < ARF_REGS; a++) begin
                map[a] <= PRF_IDX'(a);      // identity
            end
        end else begin
            for (int i = 0; i < ID_WIDTH; i++) begin    // younger slot wins
                if (commit[i].valid) begin
                    map[commit[i].rd_arch] <= commit[i].rd_phy;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- commit_backend.sv
`timescale 1ns/1ps
`default_nettype none

module commit_backend
import cpu_pkg::*;
#(
    parameter int CB_DEPTH = 4
)
(
    input  logic                    clk,
    input  logic                    rst,

    input  dispatch_t               dispatch,
    output logic                    rob_ready,
    output logic [ROB_ID_W-1:0]     rob_ids [ID_WIDTH],

    input  cdb_t                    cdb [CDB_WIDTH],

    input  br_alloc_t               br_alloc,
    output logic                    cb_full,
    input  br_resolve_t             br_resolve,

    output logic                    flush,
    output logic [31:0]             redirect_pc,

    output commit_t                 commit [ID_WIDTH],
    output freed_t                  freed  [ID_WIDTH]
);

    cb_head_t   cb_head;
    logic       cb_dequeue;

    rob u_rob (
        .clk            (clk),
        .rst            (rst),
        .dispatch       (dispatch),
        .rob_ready      (rob_ready),
        .rob_ids        (rob_ids),
        .cdb            (cdb),
        .cb_head        (cb_head),
        .cb_dequeue     (cb_dequeue),
        .flush          (flush),
        .redirect_pc    (redirect_pc),
        .commit         (commit)
    );

    control_buffer #(
        .CB_DEPTH       (CB_DEPTH)
    ) u_control_buffer (
        .clk            (clk),
        .rst            (rst),
        .br_alloc       (br_alloc),
        .cb_full        (cb_full),
        .br_resolve     (br_resolve),
        .cb_head        (cb_head),
        .cb_dequeue     (cb_dequeue),
        .flush          (flush)
    );

    rrf u_rrf (
        .clk            (clk),
        .rst            (rst),
        .commit         (commit),
        .freed          (freed)
    );

endmodule

`default_nettype wire

//--- commit_backend_assertions.sv
`timescale 1ns/1ps
`default_nettype none

module commit_backend_assertions
import cpu_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  dispatch_t   dispatch,
    input  logic        rob_ready,
    input  logic        cb_dequeue,
    input  logic        flush,
    input  commit_t     commit [ID_WIDTH],
    input  freed_t      freed  [ID_WIDTH]
);

    localparam int CW = ROB_IDX + 1;

    int                     fail_count = 0;
    logic [CW-1:0]          rows;       // rows held by the rob
    logic [ID_WIDTH-1:0]    commit_valids;
    logic [ID_WIDTH-1:0]    freed_valids;

    always_comb begin
        for (int i = 0; i < ID_WIDTH; i++) begin
            commit_valids[i] = commit[i].valid;
            freed_valids[i]  = freed[i].valid;
        end
    end

    // every retiring row commits at least one slot
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            rows <= '0;
        end else begin
            rows <= rows + CW'(dispatch.valid && rob_ready) - CW'(|commit_valids);
        end
    end

    ////////////////////////////////////////

    a_empty_quiet: assert property (@(posedge clk) disable iff (rst)
        (rows == '0) |-> (commit_valids == '0))
        else begin fail_count++; $error("commit while the rob was empty"); end

    a_flush_dequeue: assert property (@(posedge clk) disable iff (rst)
        flush |-> cb_dequeue)
        else begin fail_count++; $error("flush without cb_dequeue"); end

    a_after_flush: assert property (@(posedge clk) disable iff (rst)
        flush |=> (commit_valids == '0))
        else begin fail_count++; $error("commit in the cycle after flush"); end

    a_full: assert property (@(posedge clk) disable iff (rst)
        (rows == CW'(ROB_ROWS)) |-> !rob_ready)
        else begin fail_count++; $error("rob_ready high with eight rows held"); end

    a_freed: assert property (@(posedge clk) disable iff (rst)
        freed_valids == commit_valids)
        else begin fail_count++; $error("freed valid differs from commit valid"); end

    a_reset: assert property (@(posedge clk)
        rst |=> (commit_valids == '0 && freed_valids == '0 && !flush && !cb_dequeue))
        else begin fail_count++; $error("activity right after reset"); end

endmodule

bind commit_backend commit_backend_assertions chk (
    .clk        (clk),
    .rst        (rst),
    .dispatch   (dispatch),
    .rob_ready  (rob_ready),
    .cb_dequeue (cb_dequeue),
    .flush      (flush),
    .commit     (commit),
    .freed      (freed)
);

`default_nettype wire

//--- commit_backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

module commit_backend_tb
import cpu_pkg::*;
();

    localparam int CB_DEPTH = 4;
    localparam int TMO      = 200;      // cycles allowed per wait

    logic                   clk = 1'b0;
    logic                   rst;
    dispatch_t              dispatch;
    logic                   rob_ready;
    logic [ROB_ID_W-1:0]    rob_ids [ID_WIDTH];
    cdb_t                   cdb [CDB_WIDTH];
    br_alloc_t              br_alloc;
    logic                   cb_full;
    br_resolve_t            br_resolve;
    logic                   flush;
    logic [31:0]            redirect_pc;
    commit_t                commit [ID_WIDTH];
    freed_t                 freed  [ID_WIDTH];

    // reference model
    logic [31:0]            seed = 32'hf962346b;
    commit_t                exp_q [$];      // slots still to retire in age order
    logic [ROB_ID_W-1:0]    pend_q [$];     // ids not yet completed
    logic [PRF_IDX-1:0]     arch_map [2**ARF_IDX];
    int                     tail_row = 0;   // rob row the next accepted row lands in
    bit                     exp_flush = 1'b0;
    logic [31:0]            exp_target = '0;
    int                     flush_seen = 0;
    bit                     hung = 1'b0;
    string                  cur_test = "reset";
    int                     errors = 0;
    int                     checks = 0;
    int                     tests = 0;
    int                     test_start_errors = 0;

    always #20 clk = ~clk;

    commit_backend #(.CB_DEPTH(CB_DEPTH)) uut (.*);

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand_next();
        seed = xorshift32(seed);
        return seed;
    endfunction

    task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAIL %s %s: expected %h, got %h", cur_test, what, exp, act);
        end
    endtask

    task automatic note_error(input string msg);
        errors++;
        $display("%s: %s", cur_test, msg);
    endtask

    // parks this process; the watcher below ends the run
    task automatic stall(input string msg);
        $display("%s: timeout, %s", cur_test, msg);
        hung = 1'b1;
        forever @(negedge clk);
    endtask

    task automatic send_row(input logic [1:0] mask, input bit same_arch,
                            output logic [ROB_ID_W-1:0] base);
        dispatch_t  d;
        commit_t    e;
        int         t;
        d.valid      = 1'b1;
        d.slot_valid = mask;
        for (int i = 0; i < ID_WIDTH; i++) begin
            d.rd_phy[i]  = PRF_IDX'(rand_next());
            d.rd_arch[i] = ARF_IDX'(rand_next());
        end
        if (same_arch) begin
            d.rd_arch[1] = d.rd_arch[0];
        end
        for (t = 0; t < TMO && !rob_ready; t++) @(negedge clk);
        if (!rob_ready) stall("rob_ready never rose for a new row");
        dispatch = d;
        tail_row = (tail_row + 1) % ROB_ROWS;
        base     = rob_ids[0];
        for (int i = 0; i < ID_WIDTH; i++) begin
            if (mask[i]) begin
                e.valid   = 1'b1;
                e.rd_phy  = d.rd_phy[i];
                e.rd_arch = d.rd_arch[i];
                exp_q.push_back(e);
                pend_q.push_back(rob_ids[i]);
            end
        end
        @(negedge clk);
        dispatch.valid = 1'b0;
    endtask

    // completes up to n pending ids two per cycle
    task automatic complete(input int n, input bit scramble);
        int k;
        int idx;
        k = 0;
        while (k < n && pend_q.size() > 0) begin
            for (int c = 0; c < CDB_WIDTH; c++) begin
                cdb[c].valid = 1'b0;
                if (k < n && pend_q.size() > 0) begin
                    idx = scramble ? int'(rand_next() % 32'(pend_q.size())) : 0;
                    cdb[c].valid  = 1'b1;
                    cdb[c].rob_id = pend_q[idx];
                    pend_q.delete(idx);
                    k++;
                end
            end
            @(negedge clk);
        end
        for (int c = 0; c < CDB_WIDTH; c++) cdb[c].valid = 1'b0;
    endtask

    task automatic drain();
        int t;
        for (t = 0; t < TMO && exp_q.size() > 0; t++) @(negedge clk);
        if (exp_q.size() > 0) stall("rows did not retire");
    endtask

    task automatic alloc_branch(input logic [ROB_ID_W-1:0] id);
        int t;
        for (t = 0; t < TMO && cb_full; t++) @(negedge clk);
        if (cb_full) stall("cb_full never fell for a new branch");
        br_alloc.valid  = 1'b1;
        br_alloc.rob_id = id;
        @(negedge clk);
        br_alloc.valid = 1'b0;
    endtask

    task automatic resolve_branch(input logic [ROB_ID_W-1:0] id, input bit miss,
                                  input logic [31:0] target);
        br_resolve.valid        = 1'b1;
        br_resolve.rob_id       = id;
        br_resolve.miss_predict = miss;
        br_resolve.target       = target;
        @(negedge clk);
        br_resolve.valid = 1'b0;
    endtask

    task automatic start_test(input string name);
        cur_test          = name;
        test_start_errors = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("test %s: %0d errors", cur_test, errors - test_start_errors);
    endtask

    ////////////////////////////////////////
    // retirement monitor
    ////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < ID_WIDTH; i++) begin
                if (commit[i].valid && exp_q.size() == 0) begin
                    note_error("a slot committed that was never expected");
                end else if (commit[i].valid) begin
                    check("commit", 32'(exp_q[0]), 32'(commit[i]));
                    check("freed", 32'(arch_map[exp_q[0].rd_arch]), 32'(freed[i].phy));
                    arch_map[exp_q[0].rd_arch] = exp_q[0].rd_phy;   // slot 1 sees slot 0
                    void'(exp_q.pop_front());
                end
            end
            if (flush) begin
                if (!exp_flush) note_error("flush rose without a mispredicted branch");
                else check("redirect_pc", exp_target, redirect_pc);
                exp_flush = 1'b0;
                flush_seen++;
                tail_row = 0;
                exp_q.delete();     // younger rows are gone
                pend_q.delete();
            end
        end
    end

    initial begin
        wait (hung);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    ////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////

    initial begin
        logic [ROB_ID_W-1:0]    base;
        logic [ROB_ID_W-1:0]    first;
        logic [ROB_ID_W-1:0]    br_ids [CB_DEPTH];
        int                     t;
        rst        = 1'b1;
        dispatch   = '0;
        br_alloc   = '0;
        br_resolve = '0;
        for (int c = 0; c < CDB_WIDTH; c++) cdb[c] = '0;
        for (int a = 0; a < 2**ARF_IDX; a++) arch_map[a] = PRF_IDX'(a);
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test("in_order");
        repeat (12) begin
            if (!rob_ready) complete(64, 1'b1);
            send_row(2'(rand_next() % 3 + 1), 1'b0, base);
            complete(int'(rand_next() % 4), 1'b1);
        end
        complete(64, 1'b1);
        drain();
        end_test();

        start_test("freed_regs");
        repeat (6) begin
            send_row(2'b11, 1'b1, base);
            complete(2, 1'b1);
        end
        drain();
        end_test();

        start_test("rob_full");
        first = ROB_ID_W'(tail_row * ID_WIDTH);     // ids of the first row in the batch
        repeat (ROB_ROWS) send_row(2'b11, 1'b0, base);
        check("rob_ready while full", 32'd0, 32'(rob_ready));
        complete(2, 1'b0);      // head row only
        send_row(2'b11, 1'b0, base);
        check("id after wrap", 32'(first), 32'(base));
        complete(64, 1'b1);
        drain();
        end_test();

        start_test("branch_ok");
        send_row(2'b11, 1'b0, base);
        alloc_branch(base);
        resolve_branch(base, 1'b0, rand_next());
        send_row(2'b01, 1'b0, first);
        complete(64, 1'b1);
        drain();
        end_test();

        start_test("mispredict");
        send_row(2'b11, 1'b0, base);
        alloc_branch(base);
        send_row(2'(rand_next() % 3 + 1), 1'b0, first);
        send_row(2'b11, 1'b0, first);
        exp_target = rand_next();
        exp_flush  = 1'b1;
        resolve_branch(base, 1'b1, exp_target);
        repeat (ID_WIDTH) pend_q.push_back(pend_q.pop_front());    // branch row completes last
        complete(64, 1'b0);
        for (t = 0; t < TMO && flush_seen == 0; t++) @(negedge clk);
        if (flush_seen == 0) stall("flush never rose for the mispredicted branch");
        check("rob_ready after flush", 32'd1, 32'(rob_ready));
        check("id after flush", 32'd0, 32'(rob_ids[0]));
        send_row(2'b11, 1'b0, base);
        complete(64, 1'b1);
        drain();
        end_test();

        start_test("cb_full");
        for (int b = 0; b < CB_DEPTH; b++) begin
            send_row(2'b01, 1'b0, br_ids[b]);
            alloc_branch(br_ids[b]);
        end
        check("cb_full", 32'd1, 32'(cb_full));
        for (int b = 0; b < CB_DEPTH; b++) resolve_branch(br_ids[b], 1'b0, rand_next());
        complete(1, 1'b0);
        for (t = 0; t < TMO && cb_full; t++) @(negedge clk);
        if (cb_full) stall("cb_full stayed high after the oldest branch retired");
        complete(64, 1'b1);
        drain();
        end_test();

        errors += uut.chk.fail_count;
        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- list.f
cpu_pkg.sv
rob.sv
control_buffer.sv
rrf.sv
commit_backend.sv
commit_backend_assertions.sv
commit_backend_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the commit backend testbench with verilator
set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module commit_backend_tb -f list.f -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST RESULT: PASS$" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1
